//--- tb.f
source/dcache_pkg.sv
source/dcache_cfg_regs.sv
source/dcache_array.sv
source/dcache_ctrl_fsm.sv
source/dcache_top.sv
testbench/tb_dcache_assert.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_dcache -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

//--- testbench/tb_dcache.sv
// one core request at a time; memory grant and response delays are 0 to 3 cycles
`timescale 1ns/1ps

module tb_dcache;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  logic                              req_i;
  logic                              we_i;
  logic [dcache_pkg::ADDR_WIDTH-1:0] addr_i;
  logic [dcache_pkg::WORD_WIDTH-1:0] wdata_i;
  logic [dcache_pkg::BE_WIDTH-1:0]   be_i;
  logic                              gnt_o;
  logic                              rvalid_o;
  logic [dcache_pkg::WORD_WIDTH-1:0] rdata_o;
  logic                              mem_req_o;
  logic                              mem_we_o;
  logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o;
  logic [dcache_pkg::WORD_WIDTH-1:0] mem_wdata_o;
  logic [dcache_pkg::BE_WIDTH-1:0]   mem_be_o;
  logic                              mem_gnt_i;
  logic                              mem_rvalid_i;
  logic [dcache_pkg::LINE_WIDTH-1:0] mem_rline_i;
  logic                              cfg_we_i;
  dcache_pkg::cfg_reg_e              cfg_sel_i;
  logic [dcache_pkg::WORD_WIDTH-1:0] cfg_wdata_i;
  logic [dcache_pkg::WORD_WIDTH-1:0] cfg_rdata_o;

  // two independent lfsr streams with the same seed
  logic [15:0] stim_lfsr = 16'd46;
  logic [15:0] mem_lfsr  = 16'd46;
  // word-indexed memories for the dut side and the reference side
  logic [31:0] mem [int];
  logic [31:0] ref_mem [int];
  // reference cache state
  logic        ref_valid [2][16];
  logic [7:0]  ref_tag [2][16];
  logic        ref_repl [16];
  logic        ref_en;
  int          ref_hits, ref_misses, ref_reads;
  // expected load results in grant order
  logic [31:0] exp_data [$];
  logic        exp_hit [$];
  int          exp_cycle [$];
  int          errors, checks, cycle_cnt, last_gnt_cycle, mem_reads;
  // checker and memory model scratch
  logic [31:0] chk_data;
  logic        chk_hit;
  int          chk_cycle;
  logic        mm_req, mm_hs, mm_we, rd_pending;
  logic [15:0] mm_addr, rd_addr;
  logic [31:0] mm_wdata;
  logic [3:0]  mm_be;
  int          gnt_delay, rsp_delay;

  dcache_top u_dcache_top (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(inout logic [15:0] st, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      st = st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1);
      r  = {r[30:0], st[0]};
    end
    return r;
  endfunction

  // fill pattern over the whole word index
  function automatic logic [31:0] fill_word(input int w);
    return 32'(w * 32'h0001_9e37) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_rd(input int w);
    return mem.exists(w) ? mem[w] : fill_word(w);
  endfunction

  function automatic logic [31:0] ref_rd(input int w);
    return ref_mem.exists(w) ? ref_mem[w] : fill_word(w);
  endfunction

  // reference cache predicts hit or miss, updates its state and returns the load word
  function automatic logic [31:0] ref_access(input logic we, input logic [15:0] addr,
                                             input logic [31:0] wdata, input logic [3:0] be,
                                             output logic hit);
    int          w;
    int          set;
    logic [7:0]  tag;
    int          vic;
    w   = int'(addr[15:2]);
    set = int'(addr[7:4]);
    tag = addr[15:8];
    hit = 1'b0;
    if (ref_en) begin
      for (int way = 0; way < 2; way++) begin
        if (ref_valid[way][set] && ref_tag[way][set] == tag) hit = 1'b1;
      end
      if (hit) ref_hits++;
      else ref_misses++;
      // a load miss allocates into the first invalid way or else the replacement way
      if (!hit && !we) begin
        if (!ref_valid[0][set]) vic = 0;
        else if (!ref_valid[1][set]) vic = 1;
        else begin
          vic = int'(ref_repl[set]);
          ref_repl[set] = ~ref_repl[set];
        end
        ref_valid[vic][set] = 1'b1;
        ref_tag[vic][set]   = tag;
      end
    end
    if (!hit && !we) ref_reads++;
    // write-through keeps the newest data in memory
    if (we) ref_mem[w] = merge_bytes(ref_rd(w), wdata, be);
    return ref_rd(w);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // ----------------------------------------------------------
  // core and config drivers
  // ----------------------------------------------------------
  task automatic send(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                      input logic [3:0] be);
    int          t;
    logic        hit;
    logic [31:0] exp;
    t = 0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    be_i    <= be;
    @(negedge clk_i);
    while (!gnt_o) begin
      t++;
      if (t > 200) begin
        errors++;
        $display("timeout waiting for gnt_o on address %h", addr);
        finish_run();
      end
      @(negedge clk_i);
    end
    last_gnt_cycle = cycle_cnt;
    exp = ref_access(we, addr, wdata, be, hit);
    if (!we) begin
      exp_data.push_back(exp);
      exp_hit.push_back(hit);
      exp_cycle.push_back(cycle_cnt);
    end
  endtask

  task automatic idle_bus();
    @(posedge clk_i);
    req_i <= 1'b0;
  endtask

  // wait until every load has returned
  task automatic drain();
    int t;
    t = 0;
    while (exp_data.size() != 0) begin
      t++;
      if (t > 300) begin
        errors++;
        $display("timeout waiting for %0d load results", exp_data.size());
        finish_run();
      end
      @(negedge clk_i);
    end
  endtask

  task automatic cfg_write(input dcache_pkg::cfg_reg_e sel, input logic [31:0] data);
    @(posedge clk_i);
    cfg_we_i    <= 1'b1;
    cfg_sel_i   <= sel;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    if (sel == dcache_pkg::CFG_CTRL) ref_en = data[0];
    if (sel == dcache_pkg::CFG_HITS) ref_hits = 0;
    if (sel == dcache_pkg::CFG_MISSES) ref_misses = 0;
  endtask

  task automatic cfg_check(input dcache_pkg::cfg_reg_e sel, input logic [31:0] exp);
    @(posedge clk_i);
    cfg_sel_i <= sel;
    @(negedge clk_i);
    check_value("cfg_rdata_o", cfg_rdata_o, exp);
  endtask

  // ----------------------------------------------------------
  // response checker
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && rvalid_o) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("rvalid_o seen at %0t with no load outstanding", $time);
      end else begin
        chk_data  = exp_data.pop_front();
        chk_hit   = exp_hit.pop_front();
        chk_cycle = exp_cycle.pop_front();
        check_value("rdata_o", rdata_o, chk_data);
        if (chk_hit) begin
          // a hit returns one cycle after its grant
          check_value("rvalid_o latency", 32'(cycle_cnt), 32'(chk_cycle + 1));
        end else begin
          // a miss or an uncached load returns with the memory response
          check_value("mem_rvalid_i at rvalid_o", 32'(mem_rvalid_i), 32'd1);
        end
      end
    end
  end

  // ----------------------------------------------------------
  // memory model sampled at negedge and driven at posedge
  // ----------------------------------------------------------
  always begin
    @(negedge clk_i);
    mm_req   = mem_req_o;
    mm_hs    = mem_req_o && mem_gnt_i;
    mm_we    = mem_we_o;
    mm_addr  = mem_addr_o;
    mm_wdata = mem_wdata_o;
    mm_be    = mem_be_o;
    @(posedge clk_i);
    mem_rvalid_i <= 1'b0;
    if (!rst_ni) begin
      mem_gnt_i  <= 1'b0;
      rd_pending = 1'b0;
    end else begin
      if (rd_pending) begin
        if (rsp_delay == 0) begin
          mem_rvalid_i <= 1'b1;
          for (int i = 0; i < 4; i++) begin
            mem_rline_i[i*32 +: 32] <= mem_rd(int'(rd_addr[15:4]) * 4 + i);
          end
          rd_pending = 1'b0;
        end else begin
          rsp_delay--;
        end
      end
      if (mm_hs) begin
        mem_gnt_i <= 1'b0;
        gnt_delay = int'(rand_bits(mem_lfsr, 2));
        if (mm_we) begin
          mem[int'(mm_addr[15:2])] = merge_bytes(mem_rd(int'(mm_addr[15:2])), mm_wdata, mm_be);
        end else begin
          rd_pending = 1'b1;
          rd_addr    = mm_addr;
          rsp_delay  = int'(rand_bits(mem_lfsr, 2));
          mem_reads++;
        end
      end else if (mm_req) begin
        if (gnt_delay == 0) mem_gnt_i <= 1'b1;
        else gnt_delay--;
      end
    end
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int          g [4];
    int          line;
    logic [15:0] a;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rline_i = '0;
    cfg_we_i = 1'b0;
    cfg_sel_i = dcache_pkg::CFG_CTRL;
    cfg_wdata_i = '0;
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    mem_reads = 0;
    gnt_delay = 0;
    rsp_delay = 0;
    ref_en = 1'b0;
    ref_hits = 0;
    ref_misses = 0;
    ref_reads = 0;
    foreach (ref_valid[w, s]) ref_valid[w][s] = 1'b0;
    foreach (ref_repl[s]) ref_repl[s] = 1'b0;
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    // bypass with the cache disabled
    send(1'b1, 16'h0404, 32'h1122_3344, 4'b1001);
    send(1'b0, 16'h0404, '0, '0);
    send(1'b0, 16'h7f08, '0, '0);
    idle_bus();
    drain();
    // uncached traffic leaves the counters at their reset value
    cfg_check(dcache_pkg::CFG_CTRL, 32'd0);
    cfg_check(dcache_pkg::CFG_HITS, 32'd0);
    cfg_check(dcache_pkg::CFG_MISSES, 32'd0);
    // load miss followed by a hit on the same line
    cfg_write(dcache_pkg::CFG_CTRL, 32'd1);
    cfg_check(dcache_pkg::CFG_CTRL, 32'd1);
    send(1'b0, 16'h1230, '0, '0);
    send(1'b0, 16'h1234, '0, '0);
    idle_bus();
    drain();
    // back-to-back hits must be granted every cycle
    for (int i = 0; i < 4; i++) begin
      send(1'b0, 16'(16'h1230 + i * 4), '0, '0);
      g[i] = last_gnt_cycle;
    end
    idle_bus();
    drain();
    for (int i = 1; i < 4; i++) check_value("gnt_o spacing", 32'(g[i] - g[i-1]), 32'd1);
    // store hit merged through byte enables
    send(1'b1, 16'h1238, 32'hdead_beef, 4'b0101);
    send(1'b0, 16'h1238, '0, '0);
    idle_bus();
    drain();
    // three lines in set 5
    send(1'b0, 16'h1150, '0, '0);
    send(1'b0, 16'h2250, '0, '0);
    send(1'b0, 16'h3350, '0, '0);
    send(1'b0, 16'h1154, '0, '0);
    send(1'b0, 16'h3358, '0, '0);
    send(1'b0, 16'h2250, '0, '0);
    idle_bus();
    drain();
    // random traffic over a 24-line pool with 3 lines per set
    repeat (200) begin
      line = int'(rand_bits(stim_lfsr, 5)) % 24;
      a = 16'((((line / 8) + 1) << 8) | ((line % 8) << 4) | (int'(rand_bits(stim_lfsr, 2)) << 2));
      send(rand_bits(stim_lfsr, 1) == 1, a, rand_bits(stim_lfsr, 32),
           4'(rand_bits(stim_lfsr, 4)));
      if (rand_bits(stim_lfsr, 1) == 1) idle_bus();
    end
    idle_bus();
    drain();
    // counter values and their clear
    cfg_check(dcache_pkg::CFG_HITS, 32'(ref_hits));
    cfg_check(dcache_pkg::CFG_MISSES, 32'(ref_misses));
    cfg_write(dcache_pkg::CFG_HITS, 32'd0);
    cfg_write(dcache_pkg::CFG_MISSES, 32'd0);
    cfg_check(dcache_pkg::CFG_HITS, 32'd0);
    cfg_check(dcache_pkg::CFG_MISSES, 32'd0);
    // memory contents and read count against the reference
    foreach (ref_mem[k]) check_value("memory word", mem_rd(k), ref_mem[k]);
    check_value("memory reads", 32'(mem_reads), 32'(ref_reads));
    finish_run();
  end

endmodule

//--- testbench/tb_dcache_assert.sv
// handshake assertions for dcache_top; all but the reset check are off while rst_ni is low
`timescale 1ns/1ps

module tb_dcache_assert (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              req_i,
  input logic                              gnt_o,
  input logic                              rvalid_o,
  input logic                              mem_req_o,
  input logic                              mem_gnt_i,
  input logic                              mem_we_o,
  input logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  input logic [dcache_pkg::WORD_WIDTH-1:0] mem_wdata_o,
  input logic [dcache_pkg::BE_WIDTH-1:0]   mem_be_o
);

  // no grant without a request
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_o |-> req_i)
    else $error("gnt_o without req_i");

  // memory request held stable until granted
  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_wdata_o) && $stable(mem_be_o))
    else $error("memory request changed before mem_gnt_i");

  // quiet outputs while in reset
  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rvalid_o && !mem_req_o)
    else $error("rvalid_o or mem_req_o active in reset");

endmodule

bind dcache_top tb_dcache_assert u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .gnt_o       (gnt_o),
  .rvalid_o    (rvalid_o),
  .mem_req_o   (mem_req_o),
  .mem_gnt_i   (mem_gnt_i),
  .mem_we_o    (mem_we_o),
  .mem_addr_o  (mem_addr_o),
  .mem_wdata_o (mem_wdata_o),
  .mem_be_o    (mem_be_o)
);

//--- source/dcache_top.sv
// dcache top; single core port, one outstanding memory request, config via one-cycle strobe
`timescale 1ns/1ps

module dcache_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // core port
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0] wdata_i,
  input  logic [dcache_pkg::BE_WIDTH-1:0]   be_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0] rdata_o,
  // memory port
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0] mem_wdata_o,
  output logic [dcache_pkg::BE_WIDTH-1:0]   mem_be_o,
  input  logic                              mem_gnt_i,
  input  logic                              mem_rvalid_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0] mem_rline_i,
  // configuration port
  input  logic                              cfg_we_i,
  input  dcache_pkg::cfg_reg_e              cfg_sel_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0] cfg_wdata_i,
  output logic [dcache_pkg::WORD_WIDTH-1:0] cfg_rdata_o
);

  // config block links
  logic                              enable;
  logic                              hit_pulse;
  logic                              miss_pulse;
  // array lookup
  logic                              rd_en;
  logic [dcache_pkg::SET_WIDTH-1:0]  rd_set;
  logic [dcache_pkg::TAG_WIDTH-1:0]  rd_tag;
  logic [dcache_pkg::NUM_WAYS-1:0]   hit_way;
  logic [dcache_pkg::LINE_WIDTH-1:0] hit_line;
  logic                              victim_way;
  // array write
  logic                              wr_en;
  logic                              wr_way;
  logic [dcache_pkg::SET_WIDTH-1:0]  wr_set;
  logic [dcache_pkg::TAG_WIDTH-1:0]  wr_tag;
  logic [dcache_pkg::LINE_WIDTH-1:0] wr_line;
  logic [dcache_pkg::LINE_BYTES-1:0] wr_be;
  logic                              refill;

  dcache_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_we_i     (cfg_we_i),
    .cfg_sel_i    (cfg_sel_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .hit_pulse_i  (hit_pulse),
    .miss_pulse_i (miss_pulse),
    .cfg_rdata_o  (cfg_rdata_o),
    .enable_o     (enable)
  );

  dcache_array u_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .rd_set_i     (rd_set),
    .rd_tag_i     (rd_tag),
    .wr_en_i      (wr_en),
    .wr_way_i     (wr_way),
    .wr_set_i     (wr_set),
    .wr_tag_i     (wr_tag),
    .wr_line_i    (wr_line),
    .wr_be_i      (wr_be),
    .refill_i     (refill),
    .hit_way_o    (hit_way),
    .hit_line_o   (hit_line),
    .victim_way_o (victim_way)
  );

  dcache_ctrl_fsm u_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .enable_i     (enable),
    .rd_en_o      (rd_en),
    .rd_set_o     (rd_set),
    .rd_tag_o     (rd_tag),
    .hit_way_i    (hit_way),
    .hit_line_i   (hit_line),
    .victim_way_i (victim_way),
    .wr_en_o      (wr_en),
    .wr_way_o     (wr_way),
    .wr_set_o     (wr_set),
    .wr_tag_o     (wr_tag),
    .wr_line_o    (wr_line),
    .wr_be_o      (wr_be),
    .refill_o     (refill),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_be_o     (mem_be_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rline_i  (mem_rline_i),
    .hit_pulse_o  (hit_pulse),
    .miss_pulse_o (miss_pulse)
  );

endmodule

//--- source/dcache_ctrl_fsm.sv
// blocking controller, one miss at a time; stores are write-through no-allocate, core holds fields until gnt_o
`timescale 1ns/1ps

module dcache_ctrl_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // core port
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0] wdata_i,
  input  logic [dcache_pkg::BE_WIDTH-1:0]   be_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0] rdata_o,
  // cache enable from the config block
  input  logic                              enable_i,
  // array lookup
  output logic                              rd_en_o,
  output logic [dcache_pkg::SET_WIDTH-1:0]  rd_set_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]  rd_tag_o,
  input  logic [dcache_pkg::NUM_WAYS-1:0]   hit_way_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0] hit_line_i,
  input  logic                              victim_way_i,
  // array write
  output logic                              wr_en_o,
  output logic                              wr_way_o,
  output logic [dcache_pkg::SET_WIDTH-1:0]  wr_set_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]  wr_tag_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0] wr_line_o,
  output logic [dcache_pkg::LINE_BYTES-1:0] wr_be_o,
  output logic                              refill_o,
  // memory port
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0] mem_wdata_o,
  output logic [dcache_pkg::BE_WIDTH-1:0]   mem_be_o,
  input  logic                              mem_gnt_i,
  input  logic                              mem_rvalid_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0] mem_rline_i,
  // counter events
  output logic                              hit_pulse_o,
  output logic                              miss_pulse_o
);

  dcache_pkg::ctrl_state_e state_q, state_d;

  // saved request
  logic [dcache_pkg::ADDR_WIDTH-1:0]     addr_q;
  logic [dcache_pkg::WORD_WIDTH-1:0]     wdata_q;
  logic [dcache_pkg::BE_WIDTH-1:0]       be_q;
  logic                                  we_q;
  logic                                  bypass_q;
  logic                                  hit_way_q;
  logic                                  capture;
  logic [dcache_pkg::WORD_IDX_WIDTH-1:0] word_idx;
  logic [dcache_pkg::LINE_WIDTH-1:0]     src_line;
  logic [dcache_pkg::LINE_BYTES-1:0]     be_line;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= dcache_pkg::IDLE;
      we_q      <= 1'b0;
      bypass_q  <= 1'b0;
      hit_way_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        we_q     <= we_i;
        bypass_q <= !enable_i;
      end
      // remember which way hit for the store write
      if (state_q == dcache_pkg::LOOKUP) begin
        hit_way_q <= hit_way_i[1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  // lookup uses the live address, writes use the saved one
  assign rd_set_o = addr_i[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::SET_WIDTH];
  assign rd_tag_o = addr_i[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
  assign wr_set_o = addr_q[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::SET_WIDTH];
  assign wr_tag_o = addr_q[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
  assign word_idx = addr_q[dcache_pkg::BYTE_OFF_WIDTH +: dcache_pkg::WORD_IDX_WIDTH];
  assign be_line  = {{(dcache_pkg::LINE_BYTES - dcache_pkg::BE_WIDTH){1'b0}}, be_q};

  // ----------------------------------------------------------
  // memory request, all fields from registers
  // ----------------------------------------------------------
  // writes use a word address, reads a line address
  assign mem_we_o    = we_q;
  assign mem_addr_o  = we_q ?
      {addr_q[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::BYTE_OFF_WIDTH],
       {dcache_pkg::BYTE_OFF_WIDTH{1'b0}}} :
      {addr_q[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::OFFSET_WIDTH],
       {dcache_pkg::OFFSET_WIDTH{1'b0}}};
  assign mem_wdata_o = wdata_q;
  assign mem_be_o    = be_q;

  // critical word comes from the hit line or the memory line
  assign src_line = (state_q == dcache_pkg::LOOKUP) ? hit_line_i : mem_rline_i;
  assign rdata_o  = src_line[word_idx*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];

  // ----------------------------------------------------------
  // request FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    capture      = 1'b0;
    gnt_o        = 1'b0;
    rvalid_o     = 1'b0;
    rd_en_o      = 1'b0;
    wr_en_o      = 1'b0;
    wr_way_o     = hit_way_q;
    wr_line_o    = {dcache_pkg::WORDS_PER_LINE{wdata_q}};
    wr_be_o      = '0;
    refill_o     = 1'b0;
    mem_req_o    = 1'b0;
    hit_pulse_o  = 1'b0;
    miss_pulse_o = 1'b0;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (req_i) begin
          capture = 1'b1;
          // loads are granted on accept, stores on the memory grant
          gnt_o   = !we_i;
          if (enable_i) begin
            rd_en_o = 1'b1;
            state_d = dcache_pkg::LOOKUP;
          end else begin
            state_d = dcache_pkg::MEM_REQ;
          end
        end
      end
      dcache_pkg::LOOKUP: begin
        if (|hit_way_i) begin
          hit_pulse_o = 1'b1;
          if (we_q) begin
            state_d = dcache_pkg::STORE_WRITE;
          end else begin
            rvalid_o = 1'b1;
            state_d  = dcache_pkg::IDLE;
            // pipelined accept of the next load
            if (req_i && !we_i && enable_i) begin
              capture = 1'b1;
              gnt_o   = 1'b1;
              rd_en_o = 1'b1;
              state_d = dcache_pkg::LOOKUP;
            end
          end
        end else begin
          // load misses refill, store misses only write memory
          miss_pulse_o = 1'b1;
          state_d      = dcache_pkg::MEM_REQ;
        end
      end
      dcache_pkg::STORE_WRITE: begin
        // merge the word into the hit line through its byte enables
        wr_en_o = 1'b1;
        wr_be_o = be_line << (word_idx * dcache_pkg::BE_WIDTH);
        state_d = dcache_pkg::MEM_REQ;
      end
      dcache_pkg::MEM_REQ: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          if (we_q) begin
            gnt_o   = 1'b1;
            state_d = dcache_pkg::IDLE;
          end else if (bypass_q) begin
            state_d = dcache_pkg::BYPASS_WAIT;
          end else begin
            state_d = dcache_pkg::MEM_WAIT;
          end
        end
      end
      dcache_pkg::MEM_WAIT: begin
        if (mem_rvalid_i) begin
          rvalid_o  = 1'b1;
          state_d   = dcache_pkg::IDLE;
          // refill into the victim, skipped if the cache got disabled meanwhile
          wr_en_o   = enable_i;
          refill_o  = enable_i;
          wr_way_o  = victim_way_i;
          wr_line_o = mem_rline_i;
          wr_be_o   = '1;
        end
      end
      dcache_pkg::BYPASS_WAIT: begin
        if (mem_rvalid_i) begin
          rvalid_o = 1'b1;
          state_d  = dcache_pkg::IDLE;
        end
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
  end

endmodule

//--- source/dcache_array.sv
// 2-way storage; lookup result one cycle after rd_en_i, victim refers to the last looked-up set
`timescale 1ns/1ps

module dcache_array (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // lookup
  input  logic                                rd_en_i,
  input  logic [dcache_pkg::SET_WIDTH-1:0]    rd_set_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]    rd_tag_i,
  // write and refill
  input  logic                                wr_en_i,
  input  logic                                wr_way_i,
  input  logic [dcache_pkg::SET_WIDTH-1:0]    wr_set_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]    wr_tag_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]   wr_line_i,
  input  logic [dcache_pkg::LINE_BYTES-1:0]   wr_be_i,
  input  logic                                refill_i,
  // compare result
  output logic [dcache_pkg::NUM_WAYS-1:0]     hit_way_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]   hit_line_o,
  output logic                                victim_way_o
);

  // tag and data storage, indexed [way][set]
  logic [dcache_pkg::TAG_WIDTH-1:0]  tag_q  [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  logic [dcache_pkg::LINE_WIDTH-1:0] data_q [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
  // valid bits per set and way, one replacement bit per set
  logic [dcache_pkg::NUM_SETS-1:0][dcache_pkg::NUM_WAYS-1:0] valid_q;
  logic [dcache_pkg::NUM_SETS-1:0]                           repl_q;
  // registered lookup address
  logic [dcache_pkg::SET_WIDTH-1:0] rd_set_q;
  logic [dcache_pkg::TAG_WIDTH-1:0] rd_tag_q;
  logic [dcache_pkg::NUM_WAYS-1:0]  set_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_set_q <= '0;
      rd_tag_q <= '0;
    end else if (rd_en_i) begin
      rd_set_q <= rd_set_i;
      rd_tag_q <= rd_tag_i;
    end
  end

  // ----------------------------------------------------------
  // tag compare and way select
  // ----------------------------------------------------------
  always_comb begin
    hit_way_o  = '0;
    hit_line_o = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      hit_way_o[w] = valid_q[rd_set_q][w] && (tag_q[w][rd_set_q] == rd_tag_q);
      if (hit_way_o[w]) begin
        hit_line_o = data_q[w][rd_set_q];
      end
    end
  end

  // first invalid way wins, else round robin via the set's replacement bit
  assign set_valid = valid_q[rd_set_q];

  always_comb begin
    if (!set_valid[0]) begin
      victim_way_o = 1'b0;
    end else if (!set_valid[1]) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = repl_q[rd_set_q];
    end
  end

  // ----------------------------------------------------------
  // state update
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      repl_q  <= '0;
    end else if (wr_en_i && refill_i) begin
      valid_q[wr_set_i][wr_way_i] <= 1'b1;
      // flip only when the set was already full
      if (&valid_q[wr_set_i]) begin
        repl_q[wr_set_i] <= ~repl_q[wr_set_i];
      end
    end
  end

  // byte-masked write, a refill always covers the whole line
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      if (refill_i) begin
        tag_q[wr_way_i][wr_set_i] <= wr_tag_i;
      end
      for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
        if (wr_be_i[b] || refill_i) begin
          data_q[wr_way_i][wr_set_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- source/dcache_cfg_regs.sv
// enable bit plus saturating hit/miss counters; write is a one-cycle strobe, read is combinational
`timescale 1ns/1ps

module dcache_cfg_regs (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cfg_we_i,
  input  dcache_pkg::cfg_reg_e              cfg_sel_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0] cfg_wdata_i,
  input  logic                              hit_pulse_i,
  input  logic                              miss_pulse_i,
  output logic [dcache_pkg::WORD_WIDTH-1:0] cfg_rdata_o,
  output logic                              enable_o
);

  logic                             enable_q;
  logic [dcache_pkg::CNT_WIDTH-1:0] hits_q;
  logic [dcache_pkg::CNT_WIDTH-1:0] misses_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      hits_q   <= '0;
      misses_q <= '0;
    end else begin
      // only bit 0 of CFG_CTRL is implemented
      if (cfg_we_i && (cfg_sel_i == dcache_pkg::CFG_CTRL)) begin
        enable_q <= cfg_wdata_i[0];
      end
      // a software write clears, otherwise count up to all ones
      if (cfg_we_i && (cfg_sel_i == dcache_pkg::CFG_HITS)) begin
        hits_q <= '0;
      end else if (hit_pulse_i && !(&hits_q)) begin
        hits_q <= hits_q + 1'b1;
      end
      if (cfg_we_i && (cfg_sel_i == dcache_pkg::CFG_MISSES)) begin
        misses_q <= '0;
      end else if (miss_pulse_i && !(&misses_q)) begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  // read mux, counters zero-extended to a word
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_sel_i)
      dcache_pkg::CFG_CTRL:   cfg_rdata_o[0] = enable_q;
      dcache_pkg::CFG_HITS:   cfg_rdata_o[dcache_pkg::CNT_WIDTH-1:0] = hits_q;
      dcache_pkg::CFG_MISSES: cfg_rdata_o[dcache_pkg::CNT_WIDTH-1:0] = misses_q;
      default:                cfg_rdata_o = '0;
    endcase
  end

  assign enable_o = enable_q;

endmodule

//--- source/dcache_pkg.sv
// shared dcache geometry and enums; field widths assume a 16-bit byte address and exactly 2 ways
package dcache_pkg;

  // ----------------------------------------------------------
  // address and data geometry
  // ----------------------------------------------------------
  // byte address from the core
  localparam int ADDR_WIDTH = 16;
  // core data word and its byte enables
  localparam int WORD_WIDTH = 32;
  localparam int BE_WIDTH = 4;
  // one line is four words
  localparam int LINE_WIDTH = 128;
  localparam int LINE_BYTES = LINE_WIDTH / 8;
  localparam int WORDS_PER_LINE = 4;
  // byte offset inside a word, word index inside a line
  localparam int BYTE_OFF_WIDTH = 2;
  localparam int WORD_IDX_WIDTH = 2;
  // address split is {tag, set, offset}
  localparam int OFFSET_WIDTH = 4;
  localparam int SET_WIDTH = 4;
  localparam int NUM_SETS = 16;
  localparam int TAG_WIDTH = 8;
  localparam int NUM_WAYS = 2;
  // hit and miss counters saturate at this width
  localparam int CNT_WIDTH = 16;

  // ----------------------------------------------------------
  // controller FSM states
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    // waiting for a core request
    IDLE,
    // tag compare result from the array is valid
    LOOKUP,
    // byte-masked write of a store hit
    STORE_WRITE,
    // memory request held until mem_gnt_i
    MEM_REQ,
    // cacheable load miss, line refill pending
    MEM_WAIT,
    // uncached load, data pending
    BYPASS_WAIT
  } ctrl_state_e;

  // configuration register select
  typedef enum logic [1:0] {
    CFG_CTRL,
    CFG_HITS,
    CFG_MISSES
  } cfg_reg_e;

endpackage
